// ==== common/pipe_defines.svh ====
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// Data path and instruction width
`define DATA_W 32

// Byte address PC
`define PC_W 9

// Memory depths in words
`define IMEM_WORDS 64
`define DMEM_WORDS 16

// Register file geometry
`define REG_ADDR_W 5
`define REG_COUNT 32

`endif

// ==== common/pipePkg.sv ====
`include "pipe_defines.svh"

package pipePkg;

	// MIPS primary opcodes, halt on the top code
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opBeq   = 6'h04,
		opAddi  = 6'h08,
		opLw    = 6'h23,
		opSw    = 6'h2B,
		opHalt  = 6'h3F
	} opcodeE;

	// R-type function field
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2A
	} functE;

	// Add on zero so a cleared struct is harmless
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluSlt = 3'd4
	} aluOpE;

	// Execute operand source
	typedef enum logic [1:0] {
		fwdReg = 2'b00,
		fwdWb  = 2'b01,
		fwdMem = 2'b10
	} fwdSelE;

	// Decoded control, all zero is a bubble
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic aluSrc;
		logic regDst;
		logic branch;
		aluOpE aluOp;
		logic isFinal;
	} ctrlT;

	typedef struct packed {
		logic stallF;
		logic stallD;
		logic flushE;
		logic forwardAD;
		logic forwardBD;
		fwdSelE forwardAE;
		fwdSelE forwardBE;
	} hazardT;

	// Register numbers and write enables seen by the hazard logic
	typedef struct packed {
		logic [`REG_ADDR_W-1:0] rsD;
		logic [`REG_ADDR_W-1:0] rtD;
		logic [`REG_ADDR_W-1:0] rsE;
		logic [`REG_ADDR_W-1:0] rtE;
		logic [`REG_ADDR_W-1:0] writeRegE;
		logic [`REG_ADDR_W-1:0] writeRegM;
		logic [`REG_ADDR_W-1:0] writeRegW;
		logic regWriteE;
		logic regWriteM;
		logic regWriteW;
		logic memToRegE;
		logic memToRegM;
	} hazInfoT;

endpackage

// ==== verilog/controlUnit.sv ====
module controlUnit
(
	input pipePkg::opcodeE opcode_i,
	input pipePkg::functE funct_i,
	output pipePkg::ctrlT ctrl_o
);

	import pipePkg::*;

	always_comb
	begin
		// Bubble unless a known encoding matches
		ctrl_o = '0;
		case (opcode_i)
			opRType:
			begin
				ctrl_o.regWrite = 1'b1;
				// Destination from rd field
				ctrl_o.regDst = 1'b1;
				case (funct_i)
					fnAdd: ctrl_o.aluOp = aluAdd;
					fnSub: ctrl_o.aluOp = aluSub;
					fnAnd: ctrl_o.aluOp = aluAnd;
					fnOr: ctrl_o.aluOp = aluOr;
					fnSlt: ctrl_o.aluOp = aluSlt;
					// Unsupported function, drop back to a bubble
					default: ctrl_o = '0;
				endcase
			end
			opAddi:
			begin
				ctrl_o.regWrite = 1'b1;
				ctrl_o.aluSrc = 1'b1;
				ctrl_o.aluOp = aluAdd;
			end
			opLw:
			begin
				// Address is base plus offset
				ctrl_o.regWrite = 1'b1;
				ctrl_o.memToReg = 1'b1;
				ctrl_o.aluSrc = 1'b1;
				ctrl_o.aluOp = aluAdd;
			end
			opSw:
			begin
				ctrl_o.memWrite = 1'b1;
				ctrl_o.aluSrc = 1'b1;
				ctrl_o.aluOp = aluAdd;
			end
			opBeq:
			begin
				// Compare happens in decode, ALU op is don't care
				ctrl_o.branch = 1'b1;
				ctrl_o.aluOp = aluSub;
			end
			// End of program marker, writes nothing
			opHalt: ctrl_o.isFinal = 1'b1;
			default: ctrl_o = '0;
		endcase
	end

endmodule

// ==== hazard/hazardUnit.sv ====
`include "pipe_defines.svh"

module hazardUnit
(
	input pipePkg::hazInfoT info_i,
	input logic branchD_i,
	output pipePkg::hazardT hazard_o
);

	import pipePkg::*;

	logic lwStall;
	logic branchStall;
	logic stall;

	// Memory stage wins over write-back, register 0 never forwards
	function automatic fwdSelE exFwd(input logic [`REG_ADDR_W-1:0] src, input hazInfoT info);
		fwdSelE sel;
		sel = fwdReg;
		if (src != '0 && src == info.writeRegM && info.regWriteM)
			sel = fwdMem;
		else if (src != '0 && src == info.writeRegW && info.regWriteW)
			sel = fwdWb;
		return sel;
	endfunction

	// --------------------
	// Forwarding
	// --------------------

	assign hazard_o.forwardAE = exFwd(info_i.rsE, info_i);
	assign hazard_o.forwardBE = exFwd(info_i.rtE, info_i);

	// Branch compare in decode takes ALU result from memory stage
	assign hazard_o.forwardAD = (info_i.rsD != '0) && (info_i.rsD == info_i.writeRegM)
		&& info_i.regWriteM;
	assign hazard_o.forwardBD = (info_i.rtD != '0) && (info_i.rtD == info_i.writeRegM)
		&& info_i.regWriteM;

	// --------------------
	// Stalls
	// --------------------

	// Load in execute feeding the instruction in decode
	assign lwStall = info_i.memToRegE
		&& ((info_i.rtE == info_i.rsD) || (info_i.rtE == info_i.rtD));

	// Branch operand still being computed in execute
	// or still being loaded in memory
	assign branchStall = branchD_i
		&& ((info_i.regWriteE
			&& ((info_i.writeRegE == info_i.rsD) || (info_i.writeRegE == info_i.rtD)))
		|| (info_i.memToRegM
			&& ((info_i.writeRegM == info_i.rsD) || (info_i.writeRegM == info_i.rtD))));

	assign stall = lwStall || branchStall;

	// Hold fetch and decode, push a bubble into execute
	assign hazard_o.stallF = stall;
	assign hazard_o.stallD = stall;
	assign hazard_o.flushE = stall;

endmodule

// ==== datapath/registerFile.sv ====
`include "pipe_defines.svh"

module registerFile
(
	input logic clk,
	input logic reset_i,
	input logic [`REG_ADDR_W-1:0] addrA_i,
	input logic [`REG_ADDR_W-1:0] addrB_i,
	input logic [`REG_ADDR_W-1:0] dbgAddr_i,
	input logic [`REG_ADDR_W-1:0] writeAddr_i,
	input logic [`DATA_W-1:0] writeData_i,
	input logic writeEn_i,
	output logic [`DATA_W-1:0] dataA_o,
	output logic [`DATA_W-1:0] dataB_o,
	output logic [`DATA_W-1:0] dbgData_o
);

	logic [`DATA_W-1:0] regs [`REG_COUNT];

	// Falling edge write so decode sees this cycle's write-back
	always_ff @(negedge clk)
	begin
		if (reset_i)
			regs <= '{default: '0};
		// Register 0 stays zero
		else if (writeEn_i && writeAddr_i != '0)
			regs[writeAddr_i] <= writeData_i;
	end

	// Asynchronous reads
	assign dataA_o = regs[addrA_i];
	assign dataB_o = regs[addrB_i];
	assign dbgData_o = regs[dbgAddr_i];

endmodule

// ==== datapath/pipeDatapath.sv ====
`include "pipe_defines.svh"

module pipeDatapath
(
	input logic clk,
	input logic reset_i,
	input logic run_i,
	input logic imemWe_i,
	input logic [$clog2(`IMEM_WORDS)-1:0] imemAddr_i,
	input logic [`DATA_W-1:0] imemData_i,
	input pipePkg::ctrlT ctrl_i,
	input pipePkg::hazardT hazard_i,
	input logic [`REG_ADDR_W-1:0] dbgAddr_i,
	output pipePkg::opcodeE opcode_o,
	output pipePkg::functE funct_o,
	output logic branchD_o,
	output pipePkg::hazInfoT hazInfo_o,
	output logic [`PC_W-1:0] pcF_o,
	output logic regWriteW_o,
	output logic [`REG_ADDR_W-1:0] writeRegW_o,
	output logic [`DATA_W-1:0] resultW_o,
	output logic finalW_o,
	output logic [`DATA_W-1:0] dbgData_o
);

	import pipePkg::*;

	localparam int IMEM_AW = $clog2(`IMEM_WORDS);
	localparam int DMEM_AW = $clog2(`DMEM_WORDS);

	typedef struct packed {
		logic [`DATA_W-1:0] instr;
		logic [`PC_W-1:0] pcPlus4;
	} fdRegT;

	typedef struct packed {
		ctrlT ctrl;
		logic [`DATA_W-1:0] rd1;
		logic [`DATA_W-1:0] rd2;
		logic [`REG_ADDR_W-1:0] rs;
		logic [`REG_ADDR_W-1:0] rt;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`DATA_W-1:0] imm;
	} deRegT;

	typedef struct packed {
		ctrlT ctrl;
		logic [`DATA_W-1:0] aluOut;
		logic [`DATA_W-1:0] writeData;
		logic [`REG_ADDR_W-1:0] writeReg;
	} emRegT;

	typedef struct packed {
		ctrlT ctrl;
		logic [`DATA_W-1:0] readData;
		logic [`DATA_W-1:0] aluOut;
		logic [`REG_ADDR_W-1:0] writeReg;
	} mwRegT;

	logic [`DATA_W-1:0] imem [`IMEM_WORDS];
	logic [`DATA_W-1:0] dmem [`DMEM_WORDS];
	logic [`PC_W-1:0] pcF, pcPlus4F, pcBranchD;
	logic [`DATA_W-1:0] instrF;
	fdRegT fdReg;
	deRegT deReg;
	emRegT emReg;
	mwRegT mwReg;
	logic haltD, haltSeen, pcSrcD, finalW;
	logic [`DATA_W-1:0] rd1D, rd2D, immD, immShD, cmpAD, cmpBD;
	logic [`DATA_W-1:0] srcAE, srcBE, writeDataE, aluOutE, resultW;
	logic [`REG_ADDR_W-1:0] writeRegE;

	// Three-way operand select for execute
	function automatic logic [`DATA_W-1:0] fwdMux(input fwdSelE sel,
		input logic [`DATA_W-1:0] regVal, input logic [`DATA_W-1:0] memVal,
		input logic [`DATA_W-1:0] wbVal);
		logic [`DATA_W-1:0] val;
		case (sel)
			fwdMem: val = memVal;
			fwdWb: val = wbVal;
			default: val = regVal;
		endcase
		return val;
	endfunction

	// --------------------
	// Fetch
	// --------------------

	// Program load only while the core is stopped
	always_ff @(posedge clk)
	begin
		if (imemWe_i && !run_i)
			imem[imemAddr_i] <= imemData_i;
	end

	assign instrF = imem[pcF[IMEM_AW+1:2]];
	assign pcPlus4F = pcF + `PC_W'(4);

	// Halt seen in decode freezes the PC for good
	always_ff @(posedge clk)
	begin
		if (reset_i)
			haltSeen <= 1'b0;
		else if (run_i && haltD && !hazard_i.stallD)
			haltSeen <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
			pcF <= '0;
		else if (run_i && !hazard_i.stallF && !haltD && !haltSeen)
			pcF <= pcSrcD ? pcBranchD : pcPlus4F;
	end

	// Zero instruction decodes to a bubble
	always_ff @(posedge clk)
	begin
		if (reset_i)
			fdReg.instr <= '0;
		else if (run_i && !hazard_i.stallD)
		begin
			fdReg.pcPlus4 <= pcPlus4F;
			fdReg.instr <= (pcSrcD || haltD || haltSeen) ? '0 : instrF;
		end
	end

	// --------------------
	// Decode
	// --------------------

	registerFile regFile
	(
		.clk(clk),
		.reset_i(reset_i),
		.addrA_i(fdReg.instr[25:21]),
		.addrB_i(fdReg.instr[20:16]),
		.dbgAddr_i(dbgAddr_i),
		.writeAddr_i(mwReg.writeReg),
		.writeData_i(resultW),
		.writeEn_i(mwReg.ctrl.regWrite && run_i),
		.dataA_o(rd1D),
		.dataB_o(rd2D),
		.dbgData_o(dbgData_o)
	);

	assign opcode_o = opcodeE'(fdReg.instr[31:26]);
	assign funct_o = functE'(fdReg.instr[5:0]);
	assign branchD_o = ctrl_i.branch;
	assign haltD = ctrl_i.isFinal;

	assign immD = {{(`DATA_W-16){fdReg.instr[15]}}, fdReg.instr[15:0]};
	assign immShD = immD << 2;
	assign pcBranchD = fdReg.pcPlus4 + immShD[`PC_W-1:0];

	// Early compare with memory stage bypass
	assign cmpAD = hazard_i.forwardAD ? emReg.aluOut : rd1D;
	assign cmpBD = hazard_i.forwardBD ? emReg.aluOut : rd2D;
	assign pcSrcD = ctrl_i.branch && (cmpAD == cmpBD);

	always_ff @(posedge clk)
	begin
		if (reset_i)
			deReg.ctrl <= '0;
		else if (run_i)
		begin
			deReg.ctrl <= hazard_i.flushE ? '0 : ctrl_i;
			deReg.rd1 <= rd1D;
			deReg.rd2 <= rd2D;
			deReg.rs <= fdReg.instr[25:21];
			deReg.rt <= fdReg.instr[20:16];
			deReg.rd <= fdReg.instr[15:11];
			deReg.imm <= immD;
		end
	end

	// --------------------
	// Execute
	// --------------------

	assign writeRegE = deReg.ctrl.regDst ? deReg.rd : deReg.rt;
	assign srcAE = fwdMux(hazard_i.forwardAE, deReg.rd1, emReg.aluOut, resultW);
	assign writeDataE = fwdMux(hazard_i.forwardBE, deReg.rd2, emReg.aluOut, resultW);
	assign srcBE = deReg.ctrl.aluSrc ? deReg.imm : writeDataE;

	always_comb
	begin
		case (deReg.ctrl.aluOp)
			aluSub: aluOutE = srcAE - srcBE;
			aluAnd: aluOutE = srcAE & srcBE;
			aluOr: aluOutE = srcAE | srcBE;
			// Signed less-than
			aluSlt: aluOutE = {{(`DATA_W-1){1'b0}}, $signed(srcAE) < $signed(srcBE)};
			default: aluOutE = srcAE + srcBE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
			emReg.ctrl <= '0;
		else if (run_i)
		begin
			emReg.ctrl <= deReg.ctrl;
			emReg.aluOut <= aluOutE;
			emReg.writeData <= writeDataE;
			emReg.writeReg <= writeRegE;
		end
	end

	// --------------------
	// Memory
	// --------------------

	// Word addressed, low two bits ignored
	always_ff @(posedge clk)
	begin
		if (run_i && emReg.ctrl.memWrite)
			dmem[emReg.aluOut[DMEM_AW+1:2]] <= emReg.writeData;
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
			mwReg.ctrl <= '0;
		else if (run_i)
		begin
			mwReg.ctrl <= emReg.ctrl;
			mwReg.readData <= dmem[emReg.aluOut[DMEM_AW+1:2]];
			mwReg.aluOut <= emReg.aluOut;
			mwReg.writeReg <= emReg.writeReg;
		end
	end

	// Sticky end flag, only bubbles follow the halt
	always_ff @(posedge clk)
	begin
		if (reset_i)
			finalW <= 1'b0;
		else if (run_i)
			finalW <= finalW || emReg.ctrl.isFinal;
	end

	// --------------------
	// Write-back
	// --------------------

	assign resultW = mwReg.ctrl.memToReg ? mwReg.readData : mwReg.aluOut;

	// Stage register numbers for the hazard unit
	assign hazInfo_o.rsD = fdReg.instr[25:21];
	assign hazInfo_o.rtD = fdReg.instr[20:16];
	assign hazInfo_o.rsE = deReg.rs;
	assign hazInfo_o.rtE = deReg.rt;
	assign hazInfo_o.writeRegE = writeRegE;
	assign hazInfo_o.writeRegM = emReg.writeReg;
	assign hazInfo_o.writeRegW = mwReg.writeReg;
	assign hazInfo_o.regWriteE = deReg.ctrl.regWrite;
	assign hazInfo_o.regWriteM = emReg.ctrl.regWrite;
	assign hazInfo_o.regWriteW = mwReg.ctrl.regWrite;
	assign hazInfo_o.memToRegE = deReg.ctrl.memToReg;
	assign hazInfo_o.memToRegM = emReg.ctrl.memToReg;

	assign pcF_o = pcF;
	assign regWriteW_o = mwReg.ctrl.regWrite;
	assign writeRegW_o = mwReg.writeReg;
	assign resultW_o = resultW;
	assign finalW_o = finalW;

endmodule

// ==== verilog/pipeTop.sv ====
`include "pipe_defines.svh"

module pipeTop
(
	input logic clk,
	input logic reset_i,
	input logic run_i,
	input logic imemWe_i,
	input logic [$clog2(`IMEM_WORDS)-1:0] imemAddr_i,
	input logic [`DATA_W-1:0] imemData_i,
	input logic [`REG_ADDR_W-1:0] dbgAddr_i,
	output logic [`PC_W-1:0] pcF_o,
	output logic regWriteW_o,
	output logic [`REG_ADDR_W-1:0] writeRegW_o,
	output logic [`DATA_W-1:0] resultW_o,
	output logic finalW_o,
	output logic stallF_o,
	output logic flushE_o,
	output logic [`DATA_W-1:0] dbgData_o
);

	import pipePkg::*;

	opcodeE opcode;
	functE funct;
	ctrlT ctrl;
	hazardT hazard;
	hazInfoT hazInfo;
	logic branchD;

	// Decoder works on the instruction in decode
	controlUnit ctrlUnit
	(
		.opcode_i(opcode),
		.funct_i(funct),
		.ctrl_o(ctrl)
	);

	// Stalls, flushes and bypass selects
	hazardUnit hazUnit
	(
		.info_i(hazInfo),
		.branchD_i(branchD),
		.hazard_o(hazard)
	);

	pipeDatapath datapath
	(
		.clk(clk),
		.reset_i(reset_i),
		.run_i(run_i),
		.imemWe_i(imemWe_i),
		.imemAddr_i(imemAddr_i),
		.imemData_i(imemData_i),
		.ctrl_i(ctrl),
		.hazard_i(hazard),
		.dbgAddr_i(dbgAddr_i),
		.opcode_o(opcode),
		.funct_o(funct),
		.branchD_o(branchD),
		.hazInfo_o(hazInfo),
		.pcF_o(pcF_o),
		.regWriteW_o(regWriteW_o),
		.writeRegW_o(writeRegW_o),
		.resultW_o(resultW_o),
		.finalW_o(finalW_o),
		.dbgData_o(dbgData_o)
	);

	// Hazard status for observation
	assign stallF_o = hazard.stallF;
	assign flushE_o = hazard.flushE;

endmodule

// ==== bench/pipeTb.sv ====
`include "pipe_defines.svh"

module pipeTb;

	localparam int NUM_TESTS = 5;
	localparam int PROG_LEN = 8;
	localparam int MAX_CHECKS = 8;
	localparam int TEST_CYCLES = 150;
	// Budget of 200 cycles per table entry plus the reset-state test
	localparam int WATCHDOG_CYCLES = (NUM_TESTS + 1) * 200;

	// MIPS encodings
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_ADDI = 6'h08;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2B;
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2A;
	localparam logic [31:0] HALT = 32'hFC00_0000;

	logic clk;
	logic reset_i;
	logic run_i;
	logic imemWe_i;
	logic [$clog2(`IMEM_WORDS)-1:0] imemAddr_i;
	logic [`DATA_W-1:0] imemData_i;
	logic [`REG_ADDR_W-1:0] dbgAddr_i;
	logic [`PC_W-1:0] pcF_o;
	logic regWriteW_o;
	logic [`REG_ADDR_W-1:0] writeRegW_o;
	logic [`DATA_W-1:0] resultW_o;
	logic finalW_o;
	logic stallF_o;
	logic flushE_o;
	logic [`DATA_W-1:0] dbgData_o;

	// Stimulus table
	string testName [NUM_TESTS];
	logic [31:0] prog [NUM_TESTS][PROG_LEN];
	logic [4:0] chkReg [NUM_TESTS][MAX_CHECKS];
	logic [31:0] chkVal [NUM_TESTS][MAX_CHECKS];
	int chkCount [NUM_TESTS];
	int expStalls [NUM_TESTS];
	bit expFlush [NUM_TESTS];
	bit doPause [NUM_TESTS];

	int seed = 84;
	int errors;
	int testsFailed;
	int errBefore;
	string curName;

	pipeTop dut
	(
		.clk(clk),
		.reset_i(reset_i),
		.run_i(run_i),
		.imemWe_i(imemWe_i),
		.imemAddr_i(imemAddr_i),
		.imemData_i(imemData_i),
		.dbgAddr_i(dbgAddr_i),
		.pcF_o(pcF_o),
		.regWriteW_o(regWriteW_o),
		.writeRegW_o(writeRegW_o),
		.resultW_o(resultW_o),
		.finalW_o(finalW_o),
		.stallF_o(stallF_o),
		.flushE_o(flushE_o),
		.dbgData_o(dbgData_o)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// --------------------
	// Encoders and table
	// --------------------

	function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] fn);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic expectReg(input int t, input logic [4:0] r, input logic [31:0] v);
		chkReg[t][chkCount[t]] = r;
		chkVal[t][chkCount[t]] = v;
		chkCount[t]++;
	endtask

	task automatic fillTable();
		logic [15:0] i1;
		logic [15:0] i2;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		logic [31:0] r4;
		logic [31:0] r5;
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			// Unused slots end the program
			for (int i = 0; i < PROG_LEN; i++)
				prog[t][i] = HALT;
			chkCount[t] = 0;
			doPause[t] = 1'b0;
		end
		// Dependent ALU chain with random immediates
		i1 = $random(seed);
		i2 = $random(seed);
		r1 = {{16{i1[15]}}, i1};
		r2 = {{16{i2[15]}}, i2};
		r3 = r1 + r2;
		r4 = r3 - r1;
		r5 = r4 & r3;
		testName[0] = "alu chain";
		prog[0][0] = encI(OP_ADDI, 0, 1, i1);
		prog[0][1] = encI(OP_ADDI, 0, 2, i2);
		prog[0][2] = encR(1, 2, 3, FN_ADD);
		prog[0][3] = encR(3, 1, 4, FN_SUB);
		prog[0][4] = encR(4, 3, 5, FN_AND);
		prog[0][5] = encR(5, 1, 6, FN_OR);
		prog[0][6] = encR(1, 2, 7, FN_SLT);
		expectReg(0, 1, r1);
		expectReg(0, 2, r2);
		expectReg(0, 3, r3);
		expectReg(0, 4, r4);
		expectReg(0, 5, r5);
		expectReg(0, 6, r5 | r1);
		expectReg(0, 7, ($signed(r1) < $signed(r2)) ? 32'd1 : 32'd0);
		expStalls[0] = 0;
		expFlush[0] = 1'b0;
		// Load then dependent add
		testName[1] = "load use";
		prog[1][0] = encI(OP_ADDI, 0, 1, 16'h1234);
		prog[1][1] = encI(OP_SW, 0, 1, 16'd8);
		prog[1][2] = encI(OP_LW, 0, 2, 16'd8);
		prog[1][3] = encR(2, 1, 3, FN_ADD);
		expectReg(1, 1, 32'h0000_1234);
		expectReg(1, 2, 32'h0000_1234);
		expectReg(1, 3, 32'h0000_2468);
		expStalls[1] = 1;
		expFlush[1] = 1'b1;
		// Taken beq to word 5 and a not-taken beq after it
		testName[2] = "branches";
		prog[2][0] = encI(OP_ADDI, 0, 1, 16'd5);
		prog[2][1] = encI(OP_ADDI, 0, 2, 16'd5);
		prog[2][2] = encI(OP_BEQ, 1, 2, 16'd2);
		prog[2][3] = encI(OP_ADDI, 0, 3, 16'd7);
		prog[2][4] = encI(OP_ADDI, 0, 4, 16'd9);
		prog[2][5] = encI(OP_BEQ, 1, 0, 16'd1);
		prog[2][6] = encI(OP_ADDI, 0, 5, 16'd11);
		expectReg(2, 1, 32'd5);
		expectReg(2, 2, 32'd5);
		expectReg(2, 3, 32'd0);
		expectReg(2, 4, 32'd0);
		expectReg(2, 5, 32'd11);
		// Branch waits one cycle on addi in execute
		expStalls[2] = 1;
		expFlush[2] = 1'b1;
		// Store, reload, register 0 write
		testName[3] = "store load r0";
		prog[3][0] = encI(OP_ADDI, 0, 1, 16'hFFFD);
		prog[3][1] = encI(OP_SW, 0, 1, 16'd4);
		prog[3][2] = encI(OP_ADDI, 0, 0, 16'd99);
		prog[3][3] = encI(OP_LW, 0, 2, 16'd4);
		prog[3][4] = encR(0, 1, 4, FN_ADD);
		expectReg(3, 0, 32'd0);
		expectReg(3, 1, 32'hFFFF_FFFD);
		expectReg(3, 2, 32'hFFFF_FFFD);
		expectReg(3, 4, 32'hFFFF_FFFD);
		expectReg(3, 9, 32'd0);
		expStalls[3] = 0;
		expFlush[3] = 1'b0;
		// Frozen for 10 cycles mid program
		testName[4] = "run pause";
		prog[4][0] = encI(OP_ADDI, 0, 1, 16'd100);
		prog[4][1] = encI(OP_ADDI, 1, 2, 16'hFFD8);
		prog[4][2] = encR(1, 2, 3, FN_SUB);
		prog[4][3] = encR(2, 1, 4, FN_SLT);
		expectReg(4, 1, 32'd100);
		expectReg(4, 2, 32'd60);
		expectReg(4, 3, 32'd40);
		expectReg(4, 4, 32'd1);
		expStalls[4] = 0;
		expFlush[4] = 1'b0;
		doPause[4] = 1'b1;
	endtask

	// --------------------
	// Helpers
	// --------------------

	task automatic checkValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("CHECK FAILED %s %s: expected %h, actual %h", curName, what,
				expected, actual);
			errors++;
		end
	endtask

	// Each write-back goes to a listed register and carries its final value
	task automatic checkWriteBack(input int t, input logic [4:0] r, input logic [31:0] v);
		bit listed;
		listed = 1'b0;
		for (int k = 0; k < chkCount[t]; k++)
		begin
			if (chkReg[t][k] == r)
			begin
				listed = 1'b1;
				checkValue($sformatf("write-back r%0d", r), chkVal[t][k], v);
			end
		end
		assert (listed)
		else
		begin
			$display("Test %s: unexpected write-back to r%0d", curName, r);
			errors++;
		end
	endtask

	// All tasks start and end 1 unit after a rising edge
	task automatic resetCore();
		@(posedge clk);
		#1;
		reset_i = 1'b1;
		run_i = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		reset_i = 1'b0;
	endtask

	task automatic loadProgram(input int t);
		for (int i = 0; i < PROG_LEN; i++)
		begin
			imemWe_i = 1'b1;
			imemAddr_i = i;
			imemData_i = prog[t][i];
			@(posedge clk);
			#1;
		end
		imemWe_i = 1'b0;
	endtask

	// Register file only changes on falling edges
	task automatic readReg(input logic [4:0] r, output logic [31:0] val);
		dbgAddr_i = r;
		@(posedge clk);
		val = dbgData_o;
		#1;
	endtask

	task automatic pauseCore();
		logic [`PC_W-1:0] pcHeld;
		logic wbHeld;
		run_i = 1'b0;
		pcHeld = pcF_o;
		wbHeld = regWriteW_o;
		repeat (10)
		begin
			@(negedge clk);
			checkValue("pcF_o while paused", pcHeld, pcF_o);
			checkValue("regWriteW_o while paused", wbHeld, regWriteW_o);
		end
		@(posedge clk);
		#1;
		run_i = 1'b1;
	endtask

	task automatic reportTest();
		if (errors == errBefore)
			$display("test %-14s ok", curName);
		else
		begin
			$display("test %-14s FAILED with %0d errors", curName, errors - errBefore);
			testsFailed++;
		end
	endtask

	task automatic checkResetState();
		logic [31:0] got;
		curName = "reset state";
		errBefore = errors;
		resetCore();
		checkValue("finalW_o", 32'd0, finalW_o);
		checkValue("regWriteW_o", 32'd0, regWriteW_o);
		checkValue("pcF_o", 32'd0, pcF_o);
		for (int r = 0; r < 32; r++)
		begin
			readReg(r, got);
			checkValue($sformatf("r%0d", r), 32'd0, got);
		end
		reportTest();
	endtask

	task automatic runTest(input int t);
		int stalls;
		int cycles;
		bit sawFlush;
		logic [31:0] got;
		curName = testName[t];
		errBefore = errors;
		resetCore();
		loadProgram(t);
		stalls = 0;
		cycles = 0;
		sawFlush = 1'b0;
		run_i = 1'b1;
		while (!finalW_o && cycles < TEST_CYCLES)
		begin
			// Hazard outputs settle well before the falling edge
			@(negedge clk);
			if (stallF_o)
				stalls++;
			if (flushE_o)
				sawFlush = 1'b1;
			// Register 0 writes are dropped by the register file
			if (regWriteW_o && writeRegW_o != '0)
				checkWriteBack(t, writeRegW_o, resultW_o);
			@(posedge clk);
			#1;
			cycles++;
			if (doPause[t] && cycles == 4)
				pauseCore();
		end
		assert (finalW_o)
		else
		begin
			$display("Test %s: halt never reached write-back within %0d cycles",
				curName, TEST_CYCLES);
			errors++;
		end
		checkValue("stall cycles", expStalls[t], stalls);
		checkValue("flush seen", expFlush[t], sawFlush);
		for (int k = 0; k < chkCount[t]; k++)
		begin
			readReg(chkReg[t][k], got);
			checkValue($sformatf("r%0d", chkReg[t][k]), chkVal[t][k], got);
		end
		run_i = 1'b0;
		reportTest();
	endtask

	// --------------------
	// Main sequence
	// --------------------

	initial
	begin
		reset_i = 1'b1;
		run_i = 1'b0;
		imemWe_i = 1'b0;
		imemAddr_i = '0;
		imemData_i = '0;
		dbgAddr_i = '0;
		errors = 0;
		testsFailed = 0;
		fillTable();
		for (int t = 0; t < NUM_TESTS; t++)
			runTest(t);
		// Reset after a finished program must clear everything again
		checkResetState();
		$display("%0d tests run, %0d failed, %0d check errors", NUM_TESTS + 1,
			testsFailed, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Hang guard
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the simulation appears to hang",
			WATCHDOG_CYCLES);
		$display("sim failed");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+common
common/pipePkg.sv
verilog/controlUnit.sv
hazard/hazardUnit.sv
datapath/registerFile.sv
datapath/pipeDatapath.sv
verilog/pipeTop.sv
bench/pipeTb.sv

// ==== Bender.yml ====
package:
  name: pipe_core

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/pipePkg.sv
      - verilog/controlUnit.sv
      - hazard/hazardUnit.sv
      - datapath/registerFile.sv
      - datapath/pipeDatapath.sv
      - verilog/pipeTop.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/pipeTb.sv
